// File: design/mm_cfg.svh
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// operand and result element width
`define MM_DWIDTH 16
// memory address width and depth
`define MM_AWIDTH 7
`define MM_MEM_DEPTH 128
// array dimension, also lanes per memory word
`define MM_N 4
// result diagonals written to C, 2*N-1
`define MM_DIAGS 7

`endif

// File: design/mm_pkg.sv
`include "mm_cfg.svh"

package mm_pkg;

  // one operand, or one saturated result
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // full width accumulator, product of two elements
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;

  // one memory word
  // lane 0 in the low bits
  typedef elem_t [`MM_N-1:0] vec_t;

  // address into any of the three memories
  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // run sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    WRITE,
    DONE
  } mm_state_e;

endpackage

// File: design/mm_ctrl_if.sv
// sequencer control fanned out to the datapath stages
interface mm_ctrl_if;

  // shared A/B fetch address
  mm_pkg::addr_t op_addr;
  // zeroes skew lines and accumulators
  logic clear;
  // diagonal picked by the pack stage
  logic [2:0] diag;
  // C write port, one cycle behind diag
  mm_pkg::addr_t c_addr;
  logic c_we;
  // memories owned by the sequencer
  logic run;

  modport seq (
    output op_addr,
    output clear,
    output diag,
    output c_addr,
    output c_we,
    output run
  );

  modport skew (input clear);
  modport array (input clear);
  modport pack (input diag);

  // view of the signals the top level muxes on
  modport top (input op_addr, input c_addr, input c_we, input run);

endinterface

// File: design/mm_sram.sv
`include "mm_cfg.svh"

// single port word memory, registered read
// a write returns the old word at that address
module mm_sram (
  input  logic          clk,
  input  mm_pkg::addr_t addr,
  input  mm_pkg::vec_t  wdata,
  input  logic          we,
  output mm_pkg::vec_t  rdata
);

  mm_pkg::vec_t mem [`MM_MEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wdata;
    // read before write
    rdata <= mem[addr];
  end

endmodule

// File: design/mm_sequencer.sv
`include "mm_cfg.svh"

// run control for one 4x4 tile
// fetch words 0..N-1, drain the array, then write 2N-1 diagonals
module mm_sequencer import mm_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  mm_ctrl_if.seq ctrl,
  output logic   done
);

  localparam int FETCH_LAST = `MM_N - 1;
  // last operand pair hits cell (N-1,N-1) 2N-2 cycles after the fetch ends
  localparam int DRAIN_LAST = 2 * `MM_N - 2;
  localparam int WRITE_LAST = `MM_DIAGS - 1;
  // fetch address outside FETCH, never in the operand window
  localparam addr_t PARK_ADDR = addr_t'(`MM_MEM_DEPTH - 1);

  mm_state_e state;
  mm_state_e state_nxt;
  // shared step counter, restarts on every state change
  logic [2:0] cnt;
  logic       cnt_last;
  logic       c_we_q;
  addr_t      c_addr_q;

  // end of the current state
  always_comb
  begin
    case (state)
      FETCH:   cnt_last = (cnt == 3'(FETCH_LAST));
      DRAIN:   cnt_last = (cnt == 3'(DRAIN_LAST));
      WRITE:   cnt_last = (cnt == 3'(WRITE_LAST));
      default: cnt_last = 1'b0;
    endcase
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (start)
          state_nxt = FETCH;
      FETCH:
        if (cnt_last)
          state_nxt = DRAIN;
      DRAIN:
        if (cnt_last)
          state_nxt = WRITE;
      WRITE:
        if (cnt_last)
          state_nxt = DONE;
      default:
        state_nxt = DONE;
    endcase
    // start is a level, dropping it aborts or ends the run
    if (!start)
      state_nxt = IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= IDLE;
      cnt    <= '0;
      c_we_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state_nxt != state)
        cnt <= '0;
      else if (state == FETCH || state == DRAIN || state == WRITE)
        cnt <= cnt + 3'd1;
      // pack output lands one cycle after diag
      c_we_q <= (state == WRITE) && start;
    end
  end

  // C address trails diag by the pack register
  always_ff @(posedge clk)
  begin
    c_addr_q <= addr_t'(cnt);
  end

  assign ctrl.op_addr = (state == FETCH) ? addr_t'(cnt) : PARK_ADDR;
  assign ctrl.clear   = (state == IDLE);
  // only consumed while c_we follows
  assign ctrl.diag    = cnt;
  assign ctrl.c_addr  = c_addr_q;
  assign ctrl.c_we    = c_we_q;
  // held until IDLE so the last C write keeps its address
  assign ctrl.run     = start || (state != IDLE);
  assign done         = (state == DONE);

endmodule

// File: design/mm_skew.sv
`include "mm_cfg.svh"

// triangular delay lines in front of the array
// lane i leaves i cycles after its word arrives
module mm_skew import mm_pkg::*; (
  input  logic    clk,
  mm_ctrl_if.skew ctrl,
  input  vec_t    a_word,
  input  vec_t    b_word,
  output vec_t    a_lanes,
  output vec_t    b_lanes
);

  // operand 0 is A, operand 1 is B
  vec_t in_w  [2];
  vec_t out_w [2];

  assign in_w[0] = a_word;
  assign in_w[1] = b_word;

  for (genvar g = 0; g < 2; g++)
  begin : g_op
    // lane 0 needs no delay
    assign out_w[g][0] = in_w[g][0];

    for (genvar l = 1; l < `MM_N; l++)
    begin : g_lane
      // l stages, dly[0] nearest the memory
      elem_t dly [l];

      always_ff @(posedge clk)
      begin
        if (ctrl.clear)
        begin
          for (int s = 0; s < l; s++)
            dly[s] <= '0;
        end
        else
        begin
          dly[0] <= in_w[g][l];
          for (int s = 1; s < l; s++)
            dly[s] <= dly[s-1];
        end
      end

      assign out_w[g][l] = dly[l-1];
    end
  end

  assign a_lanes = out_w[0];
  assign b_lanes = out_w[1];

endmodule

// File: design/mm_pe_array.sv
`include "mm_cfg.svh"

// NxN output stationary systolic grid
// A moves right, B moves down, one cell per cycle
module mm_pe_array import mm_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  mm_ctrl_if.array ctrl,
  input  vec_t     a_lanes,
  input  vec_t     b_lanes,
  output acc_t     sums [`MM_N][`MM_N]
);

  // registered operands leaving each cell
  elem_t a_fwd [`MM_N][`MM_N];
  elem_t b_fwd [`MM_N][`MM_N];

  for (genvar i = 0; i < `MM_N; i++)
  begin : g_row
    for (genvar j = 0; j < `MM_N; j++)
    begin : g_col
      elem_t a_in;
      elem_t b_in;

      // left column takes lane i of A, top row lane j of B
      if (j == 0)
      begin : g_a_edge
        assign a_in = a_lanes[i];
      end
      else
      begin : g_a_inner
        assign a_in = a_fwd[i][j-1];
      end

      if (i == 0)
      begin : g_b_edge
        assign b_in = b_lanes[j];
      end
      else
      begin : g_b_inner
        assign b_in = b_fwd[i-1][j];
      end

      always_ff @(posedge clk)
      begin
        if (rst || ctrl.clear)
        begin
          a_fwd[i][j] <= '0;
          b_fwd[i][j] <= '0;
          sums[i][j]  <= '0;
        end
        else
        begin
          a_fwd[i][j] <= a_in;
          b_fwd[i][j] <= b_in;
          // full 32 bit product, zero operands add nothing
          sums[i][j]  <= sums[i][j] + acc_t'(a_in) * acc_t'(b_in);
        end
      end
    end
  end

endmodule

// File: design/mm_result_pack.sv
`include "mm_cfg.svh"

// saturate the sums and gather one diagonal into a C word
module mm_result_pack import mm_pkg::*; (
  input  logic    clk,
  mm_ctrl_if.pack ctrl,
  input  acc_t    sums [`MM_N][`MM_N],
  output vec_t    c_word
);

  // any bit in the upper half clamps to all ones
  function automatic elem_t saturate(acc_t s);
    if (|s[2*`MM_DWIDTH-1:`MM_DWIDTH])
      return {`MM_DWIDTH{1'b1}};
    else
      return s[`MM_DWIDTH-1:0];
  endfunction

  vec_t diag_word;

  // lane i carries C[i][d-i], zero off the matrix
  always_comb
  begin
    int col;

    diag_word = '0;
    for (int i = 0; i < `MM_N; i++)
    begin
      col = int'(ctrl.diag) - i;
      if (col >= 0 && col < `MM_N)
        diag_word[i] = saturate(sums[i][col]);
    end
  end

  // one cycle behind diag
  // lines up with c_we from the sequencer
  always_ff @(posedge clk)
  begin
    c_word <= diag_word;
  end

endmodule

// File: design/mm_top.sv
`include "mm_cfg.svh"

// 4x4 unsigned matrix multiplier with A, B and C memories
// host owns the memories while start is low
module mm_top import mm_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  addr_t host_addr,
  input  vec_t  host_wdata,
  input  logic  we_a,
  input  logic  we_b,
  output vec_t  host_rdata,
  output logic  done
);

  mm_ctrl_if ctrl ();

  addr_t ab_addr;
  addr_t c_mem_addr;
  logic  a_we;
  logic  b_we;
  vec_t  a_rdata;
  vec_t  b_rdata;
  // memory output holds a fetched operand word
  logic  op_valid;
  vec_t  a_word;
  vec_t  b_word;
  vec_t  a_lanes;
  vec_t  b_lanes;
  acc_t  sums [`MM_N][`MM_N];
  vec_t  c_word;

  mm_sequencer seq_i (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .ctrl (ctrl),
    .done (done)
  );

  // address ownership follows run
  assign ab_addr    = ctrl.run ? ctrl.op_addr : host_addr;
  assign c_mem_addr = ctrl.run ? ctrl.c_addr : host_addr;
  // host writes dropped during a run
  assign a_we = we_a && !ctrl.run;
  assign b_we = we_b && !ctrl.run;

  mm_sram a_mem_i (
    .clk  (clk),
    .addr (ab_addr),
    .wdata(host_wdata),
    .we   (a_we),
    .rdata(a_rdata)
  );

  mm_sram b_mem_i (
    .clk  (clk),
    .addr (ab_addr),
    .wdata(host_wdata),
    .we   (b_we),
    .rdata(b_rdata)
  );

  // matches the read latency of the memories
  always_ff @(posedge clk)
  begin
    if (rst)
      op_valid <= 1'b0;
    else
      op_valid <= ctrl.run && (ctrl.op_addr < addr_t'(`MM_N));
  end

  // zeros outside the fetch window keep the sums clean
  assign a_word = op_valid ? a_rdata : '0;
  assign b_word = op_valid ? b_rdata : '0;

  mm_skew skew_i (
    .clk    (clk),
    .ctrl   (ctrl),
    .a_word (a_word),
    .b_word (b_word),
    .a_lanes(a_lanes),
    .b_lanes(b_lanes)
  );

  mm_pe_array array_i (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .a_lanes(a_lanes),
    .b_lanes(b_lanes),
    .sums   (sums)
  );

  mm_result_pack pack_i (
    .clk   (clk),
    .ctrl  (ctrl),
    .sums  (sums),
    .c_word(c_word)
  );

  // C read port doubles as the host readback
  mm_sram c_mem_i (
    .clk  (clk),
    .addr (c_mem_addr),
    .wdata(c_word),
    .we   (ctrl.c_we),
    .rdata(host_rdata)
  );

endmodule

// File: bench/mm_tb.sv
`include "mm_cfg.svh"

// directed testbench for the 4x4 systolic multiplier
module mm_tb import mm_pkg::*; ();

  // runs across all tests, each bounded by RUN_CYCLES
  localparam int NUM_RUNS = 7;
  localparam int RUN_CYCLES = 60;
  localparam int TIMEOUT_CYCLES = 10 + NUM_RUNS * RUN_CYCLES + 100;
  // per run bound while waiting for done
  localparam int DONE_WAIT = 100;

  logic  clk = 1'b0;
  logic  rst;
  logic  start;
  addr_t host_addr;
  vec_t  host_wdata;
  logic  we_a;
  logic  we_b;
  vec_t  host_rdata;
  logic  done;

  // matrices as the host sees them
  elem_t a_m [`MM_N][`MM_N];
  elem_t b_m [`MM_N][`MM_N];
  // C words read back, one per diagonal
  vec_t  c_read [`MM_DIAGS];

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  mm_top mm_top_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .we_a      (we_a),
    .we_b      (we_b),
    .host_rdata(host_rdata),
    .done      (done)
  );

  always #4 clk = ~clk;

  // hang guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: simulation still running after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // one host write, strobe held over a single rising edge
  task automatic write_word(input addr_t addr, input vec_t data, input bit to_a);
    @(negedge clk);
    host_addr  = addr;
    host_wdata = data;
    we_a       = to_a;
    we_b       = !to_a;
    @(negedge clk);
    we_a = 1'b0;
    we_b = 1'b0;
  endtask

  // A by columns, B by rows
  task automatic load_matrices(input bit do_a, input bit do_b);
    vec_t w;

    for (int k = 0; k < `MM_N; k++)
    begin
      if (do_a)
      begin
        for (int i = 0; i < `MM_N; i++)
          w[i] = a_m[i][k];
        write_word(addr_t'(k), w, 1'b1);
      end
      if (do_b)
      begin
        for (int j = 0; j < `MM_N; j++)
          w[j] = b_m[k][j];
        write_word(addr_t'(k), w, 1'b0);
      end
    end
  endtask

  // raise start, wait for done, leave start high
  task automatic run_multiply();
    int n;

    n = 0;
    @(negedge clk);
    start = 1'b1;
    while (!done && n < DONE_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!done)
      report_error($sformatf("done did not rise within %0d cycles of start", DONE_WAIT));
    // level output, should hold while start is high
    repeat (3) @(negedge clk);
    check_value("done held", done, 1'b1);
  endtask

  // start low hands the memories back to the host
  task automatic drop_start();
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    check_value("done after start drop", done, 1'b0);
  endtask

  // address on one falling edge, data stable by the next
  task automatic read_result();
    for (int d = 0; d < `MM_DIAGS; d++)
    begin
      @(negedge clk);
      host_addr = addr_t'(d);
      @(negedge clk);
      c_read[d] = host_rdata;
    end
  endtask

  // C[i][j] from the matrices, 32 bit accumulate, then clamp
  function automatic elem_t ref_element(input int i, input int j);
    logic [31:0] sum;

    sum = '0;
    for (int k = 0; k < `MM_N; k++)
      sum = sum + 32'(a_m[i][k]) * 32'(b_m[k][j]);
    return (sum > 32'h0000_ffff) ? 16'hffff : sum[15:0];
  endfunction

  // diagonal d, lane i holds C[i][d-i]
  function automatic vec_t ref_diag(input int d);
    vec_t w;

    w = '0;
    for (int i = 0; i < `MM_N; i++)
      if (d - i >= 0 && d - i < `MM_N)
        w[i] = ref_element(i, d - i);
    return w;
  endfunction

  task automatic compare_words(input string tag, input vec_t exp [`MM_DIAGS]);
    for (int d = 0; d < `MM_DIAGS; d++)
      for (int i = 0; i < `MM_N; i++)
        check_value($sformatf("%s C[%0d] lane %0d", tag, d, i), c_read[d][i], exp[d][i]);
  endtask

  task automatic compare_product(input string tag);
    vec_t exp [`MM_DIAGS];

    for (int d = 0; d < `MM_DIAGS; d++)
      exp[d] = ref_diag(d);
    compare_words(tag, exp);
  endtask

  task automatic fill_small(input bit do_a, input bit do_b);
    for (int i = 0; i < `MM_N; i++)
      for (int j = 0; j < `MM_N; j++)
      begin
        if (do_a)
          a_m[i][j] = elem_t'($urandom % 128);
        if (do_b)
          b_m[i][j] = elem_t'($urandom % 128);
      end
  endtask

  task automatic test_reset_idle();
    check_value("done after reset", done, 1'b0);
    repeat (5)
    begin
      @(negedge clk);
      check_value("done idle", done, 1'b0);
    end
  endtask

  // identity A gives B back in diagonal order
  task automatic test_identity();
    vec_t exp [`MM_DIAGS];

    fill_small(1'b0, 1'b1);
    for (int i = 0; i < `MM_N; i++)
      for (int j = 0; j < `MM_N; j++)
        a_m[i][j] = (i == j) ? 16'd1 : 16'd0;
    for (int d = 0; d < `MM_DIAGS; d++)
    begin
      exp[d] = '0;
      for (int i = 0; i < `MM_N; i++)
        if (d - i >= 0 && d - i < `MM_N)
          exp[d][i] = b_m[i][d-i];
    end
    load_matrices(1'b1, 1'b1);
    run_multiply();
    drop_start();
    read_result();
    compare_words("identity", exp);
  endtask

  task automatic test_random();
    for (int r = 0; r < 2; r++)
    begin
      fill_small(1'b1, 1'b1);
      load_matrices(1'b1, 1'b1);
      run_multiply();
      drop_start();
      read_result();
      compare_product($sformatf("random%0d", r));
    end
  endtask

  // every valid element overflows 16 bits
  task automatic test_saturation();
    vec_t exp [`MM_DIAGS];

    for (int i = 0; i < `MM_N; i++)
      for (int j = 0; j < `MM_N; j++)
      begin
        a_m[i][j] = 16'hfff0 | elem_t'($urandom % 16);
        b_m[i][j] = 16'hfff0 | elem_t'($urandom % 16);
      end
    for (int d = 0; d < `MM_DIAGS; d++)
      for (int i = 0; i < `MM_N; i++)
        exp[d][i] = (d - i >= 0 && d - i < `MM_N) ? 16'hffff : 16'h0000;
    load_matrices(1'b1, 1'b1);
    run_multiply();
    drop_start();
    read_result();
    compare_words("saturate", exp);
  endtask

  // back to back runs must not add up
  task automatic test_restart();
    fill_small(1'b1, 1'b1);
    load_matrices(1'b1, 1'b1);
    run_multiply();
    drop_start();
    read_result();
    compare_product("first");
    // new B only, A stays in memory
    fill_small(1'b0, 1'b1);
    load_matrices(1'b0, 1'b1);
    run_multiply();
    // start still high, these writes must be dropped
    for (int k = 0; k < `MM_N; k++)
      write_word(addr_t'(k), {4{16'h5a5a}}, 1'b0);
    drop_start();
    read_result();
    compare_product("second");
    // rerun on the same memories
    run_multiply();
    drop_start();
    read_result();
    compare_product("rerun");
  endtask

  initial
  begin
    void'($urandom(32'h6a21));
    rst        = 1'b1;
    start      = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    we_a       = 1'b0;
    we_b       = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_reset_idle();
    test_identity();
    test_random();
    test_saturation();
    test_restart();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/mm_pkg.sv
design/mm_ctrl_if.sv
design/mm_sram.sv
design/mm_sequencer.sv
design/mm_skew.sv
design/mm_pe_array.sv
design/mm_result_pack.sv
design/mm_top.sv
bench/mm_tb.sv

// File: Bender.yml
package:
  name: mm_systolic

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mm_pkg.sv
      - design/mm_ctrl_if.sv
      - design/mm_sram.sv
      - design/mm_sequencer.sv
      - design/mm_skew.sv
      - design/mm_pe_array.sv
      - design/mm_result_pack.sv
      - design/mm_top.sv
      - target: test
        files:
          - bench/mm_tb.sv
